//--- logic/ddr_read_pkg.sv
`default_nettype none

package ddr_read_pkg;

    // upstream side
    typedef logic [27:0]  word_addr_t;   // address in 32-bit words
    typedef logic [7:0]   beat_len_t;    // beats minus one
    typedef logic [3:0]   bus_id_t;
    typedef logic [31:0]  bus_data_t;
    typedef logic [1:0]   bus_resp_t;

    // DDR side
    typedef logic [3:0]   burst_len_t;   // wide words minus one
    typedef logic [255:0] ddr_data_t;    // 8 lanes, lane 0 in the low bits

    // one wide burst at most, fixed by the 4-bit length field
    localparam int unsigned DDR_BURST_MAX = 16;

    typedef enum logic [2:0] {
        idle,
        wait_data,
        trans_addr,
        trans_data,
        flush
    } read_state_t;

endpackage

`default_nettype wire

//--- logic/ddr_read_fifo.sv
`timescale 1ns/10ps
`default_nettype none

// wide in, narrow out; the output shows the head lane without a read delay
module ddr_read_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          flush,
    input  wire                          wr_en,
    input  wire ddr_read_pkg::ddr_data_t wr_data,
    input  wire                          pop,
    output ddr_read_pkg::bus_data_t      rd_data,
    output logic                         empty,
    output logic                         room
);
    import ddr_read_pkg::*;

    localparam int AW    = $clog2(FIFO_DEPTH);
    localparam int LANES = $bits(ddr_data_t) / $bits(bus_data_t);

    // room is kept for one full burst on top of what is stored
    localparam logic [AW:0] ROOM_LIMIT = (AW + 1)'(FIFO_DEPTH - DDR_BURST_MAX);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(FIFO_DEPTH);

    ddr_data_t   mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;           // extra msb tells full from empty
    logic [AW:0] rd_ptr;
    logic [2:0]  lane;             // lane index in the head word
    logic [AW:0] count;            // a partly read word still counts
    logic        full;
    logic        do_write;
    logic        do_pop;
    logic        last_lane;
    ddr_data_t   head;

    assign count     = wr_ptr - rd_ptr;
    assign full      = (count == FULL_COUNT);
    assign empty     = (count == '0);
    assign room      = (count <= ROOM_LIMIT);

    assign do_write  = wr_en && !full;
    assign do_pop    = pop && !empty;
    assign last_lane = (lane == 3'(LANES - 1));

    // head word straight from the array
    assign head    = mem[rd_ptr[AW-1:0]];
    assign rd_data = head[{lane, 5'd0} +: $bits(bus_data_t)];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // one lane per pop, head word freed after its top lane
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            rd_ptr <= '0;
            lane   <= '0;
        end else if (do_pop) begin
            if (last_lane) begin
                lane   <= '0;
                rd_ptr <= rd_ptr + 1'b1;
            end else begin
                lane <= lane + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/ddr_read_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_read_ctrl (
    input  wire                           clk,
    input  wire                           rstn,

    // upstream address channel
    input  wire ddr_read_pkg::bus_id_t    rd_addr_id,
    input  wire ddr_read_pkg::word_addr_t rd_addr,
    input  wire ddr_read_pkg::beat_len_t  rd_addr_len,
    input  wire                           rd_addr_valid,
    output logic                          rd_addr_ready,

    // upstream data channel
    output ddr_read_pkg::bus_id_t         rd_back_id,
    output ddr_read_pkg::bus_data_t       rd_data,
    output ddr_read_pkg::bus_resp_t       rd_data_resp,
    output logic                          rd_data_last,
    output logic                          rd_data_valid,
    input  wire                           rd_data_ready,

    // DDR address channel
    output ddr_read_pkg::word_addr_t      ddr_addr,
    output ddr_read_pkg::burst_len_t      ddr_len,
    output ddr_read_pkg::bus_id_t         ddr_id,
    output logic                          ddr_addr_valid,
    input  wire                           ddr_addr_ready,

    // DDR data channel, only the framing is needed here
    input  wire                           ddr_data_last,
    input  wire                           ddr_data_valid,

    // FIFO side
    input  wire ddr_read_pkg::bus_data_t  fifo_data,
    input  wire                           fifo_empty,
    input  wire                           fifo_room,
    output logic                          fifo_flush,
    output logic                          fifo_pop
);
    import ddr_read_pkg::*;

    read_state_t state;
    read_state_t state_next;

    word_addr_t  base_addr;    // next burst address, wide aligned
    bus_id_t     id_q;
    logic [5:0]  wide_left;    // wide words still to request, minus one
    logic        done;         // all bursts of the request issued
    logic [2:0]  discard_cnt;  // leading lanes to drop
    beat_len_t   beat_cnt;     // beats still to hand back, minus one

    logic        req_accept;
    logic        burst_accept;
    logic        last_burst;
    logic        busy;
    logic        discarding;
    logic        beat_xfer;
    logic [5:0]  end_wide;
    logic [5:0]  burst_words;

    assign req_accept   = rd_addr_valid && rd_addr_ready;
    assign burst_accept = ddr_addr_valid && ddr_addr_ready;

    // wide index of the last needed word, modulo 64 is enough for a 33 word span
    assign end_wide = 6'((rd_addr[8:0] + {1'b0, rd_addr_len}) >> 3);

    assign last_burst  = (wide_left <= 6'(DDR_BURST_MAX - 1));
    assign burst_words = {2'b00, ddr_len} + 6'd1;

    assign busy       = (state == wait_data) || (state == trans_addr) || (state == trans_data);
    assign discarding = busy && (discard_cnt != '0);
    assign beat_xfer  = rd_data_valid && rd_data_ready;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (req_accept) begin
                    state_next = wait_data;
                end
            end
            wait_data: begin
                if (beat_xfer && rd_data_last) begin
                    state_next = flush;
                end else if (fifo_room && !done) begin
                    state_next = trans_addr;
                end
            end
            trans_addr: begin
                if (burst_accept) begin
                    state_next = trans_data;
                end
            end
            trans_data: begin
                if (ddr_data_valid && ddr_data_last) begin
                    state_next = wait_data;
                end
            end
            flush: begin
                state_next = idle;   // leftover lanes cleared here
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            base_addr <= {rd_addr[27:3], 3'b000};
            id_q      <= rd_addr_id;
        end else if (burst_accept && !last_burst) begin
            base_addr <= base_addr + word_addr_t'({burst_words, 3'b000});
        end
    end

    // burst splitting
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wide_left <= '0;
            done      <= 1'b0;
        end else if (req_accept) begin
            wide_left <= end_wide - rd_addr[8:3];
            done      <= 1'b0;
        end else if (burst_accept) begin
            if (last_burst) begin
                done <= 1'b1;
            end else begin
                wide_left <= wide_left - burst_words;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            discard_cnt <= '0;
        end else if (req_accept) begin
            discard_cnt <= rd_addr[2:0];
        end else if (discarding && fifo_pop) begin
            discard_cnt <= discard_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (req_accept) begin
            beat_cnt <= rd_addr_len;
        end else if (beat_xfer && (beat_cnt != '0)) begin
            beat_cnt <= beat_cnt - 1'b1;
        end
    end

    assign rd_addr_ready  = (state == idle);

    assign ddr_addr       = base_addr;
    assign ddr_len        = last_burst ? wide_left[3:0] : burst_len_t'(DDR_BURST_MAX - 1);
    assign ddr_id         = id_q;
    assign ddr_addr_valid = (state == trans_addr);

    // data goes out only once the leading lanes are gone
    assign rd_data_valid  = busy && (discard_cnt == '0) && !fifo_empty;
    assign rd_data_last   = rd_data_valid && (beat_cnt == '0);
    assign rd_data        = fifo_data;
    assign rd_back_id     = id_q;   // DDR returns in order
    assign rd_data_resp   = '0;     // always okay

    assign fifo_pop       = !fifo_empty && (discarding || beat_xfer);
    assign fifo_flush     = (state == flush);

endmodule

`default_nettype wire

//--- logic/ddr_read_top.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_read_top #(
    parameter int FIFO_DEPTH = 32   // wide words, power of two, 16 or more
) (
    input  wire                           clk,
    input  wire                           rstn,

    input  wire ddr_read_pkg::bus_id_t    rd_addr_id,
    input  wire ddr_read_pkg::word_addr_t rd_addr,
    input  wire ddr_read_pkg::beat_len_t  rd_addr_len,
    input  wire                           rd_addr_valid,
    output wire                           rd_addr_ready,

    output wire ddr_read_pkg::bus_id_t    rd_back_id,
    output wire ddr_read_pkg::bus_data_t  rd_data,
    output wire ddr_read_pkg::bus_resp_t  rd_data_resp,
    output wire                           rd_data_last,
    output wire                           rd_data_valid,
    input  wire                           rd_data_ready,

    output wire ddr_read_pkg::word_addr_t ddr_addr,
    output wire ddr_read_pkg::burst_len_t ddr_len,
    output wire ddr_read_pkg::bus_id_t    ddr_id,
    output wire                           ddr_addr_valid,
    input  wire                           ddr_addr_ready,

    input  wire ddr_read_pkg::ddr_data_t  ddr_data,
    input  wire ddr_read_pkg::bus_id_t    ddr_back_id,   // in order, id comes from the request
    input  wire                           ddr_data_last,
    input  wire                           ddr_data_valid
);
    import ddr_read_pkg::*;

    bus_data_t fifo_data;
    wire       fifo_empty;
    wire       fifo_room;
    wire       fifo_flush;
    wire       fifo_pop;

    ddr_read_ctrl u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .rd_addr_id     (rd_addr_id),
        .rd_addr        (rd_addr),
        .rd_addr_len    (rd_addr_len),
        .rd_addr_valid  (rd_addr_valid),
        .rd_addr_ready  (rd_addr_ready),
        .rd_back_id     (rd_back_id),
        .rd_data        (rd_data),
        .rd_data_resp   (rd_data_resp),
        .rd_data_last   (rd_data_last),
        .rd_data_valid  (rd_data_valid),
        .rd_data_ready  (rd_data_ready),
        .ddr_addr       (ddr_addr),
        .ddr_len        (ddr_len),
        .ddr_id         (ddr_id),
        .ddr_addr_valid (ddr_addr_valid),
        .ddr_addr_ready (ddr_addr_ready),
        .ddr_data_last  (ddr_data_last),
        .ddr_data_valid (ddr_data_valid),
        .fifo_data      (fifo_data),
        .fifo_empty     (fifo_empty),
        .fifo_room      (fifo_room),
        .fifo_flush     (fifo_flush),
        .fifo_pop       (fifo_pop)
    );

    // every valid DDR word is written, no ready on that side
    ddr_read_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .flush   (fifo_flush),
        .wr_en   (ddr_data_valid),
        .wr_data (ddr_data),
        .pop     (fifo_pop),
        .rd_data (fifo_data),
        .empty   (fifo_empty),
        .room    (fifo_room)
    );

endmodule

`default_nettype wire

//--- dv/tb_ddr_read.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ddr_read;
    import ddr_read_pkg::*;

    localparam int FIFO_DEPTH = 32;
    localparam int TIMEOUT    = 20000;   // cycles allowed per wait

    logic       clk;
    logic       rstn;
    bus_id_t    rd_addr_id;
    word_addr_t rd_addr;
    beat_len_t  rd_addr_len;
    logic       rd_addr_valid;
    logic       rd_addr_ready;
    bus_id_t    rd_back_id;
    bus_data_t  rd_data;
    bus_resp_t  rd_data_resp;
    logic       rd_data_last;
    logic       rd_data_valid;
    logic       rd_data_ready;
    word_addr_t ddr_addr;
    burst_len_t ddr_len;
    bus_id_t    ddr_id;
    logic       ddr_addr_valid;
    logic       ddr_addr_ready;
    ddr_data_t  ddr_data;
    bus_id_t    ddr_back_id;
    logic       ddr_data_last;
    logic       ddr_data_valid;

    int         errors;
    int         beats_total;
    int         bursts_total;
    int         stall_pct;
    logic       req_active;      // set on address handshake, cleared on last beat
    bus_id_t    cur_id;
    word_addr_t cur_addr;
    beat_len_t  cur_len;
    int         beats_seen;
    int         words_asked;     // wide words requested by the DUT
    int         words_written;   // wide words returned by the model
    word_addr_t next_burst_addr;

    ddr_read_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .clk            (clk),
        .rstn           (rstn),
        .rd_addr_id     (rd_addr_id),
        .rd_addr        (rd_addr),
        .rd_addr_len    (rd_addr_len),
        .rd_addr_valid  (rd_addr_valid),
        .rd_addr_ready  (rd_addr_ready),
        .rd_back_id     (rd_back_id),
        .rd_data        (rd_data),
        .rd_data_resp   (rd_data_resp),
        .rd_data_last   (rd_data_last),
        .rd_data_valid  (rd_data_valid),
        .rd_data_ready  (rd_data_ready),
        .ddr_addr       (ddr_addr),
        .ddr_len        (ddr_len),
        .ddr_id         (ddr_id),
        .ddr_addr_valid (ddr_addr_valid),
        .ddr_addr_ready (ddr_addr_ready),
        .ddr_data       (ddr_data),
        .ddr_back_id    (ddr_back_id),
        .ddr_data_last  (ddr_data_last),
        .ddr_data_valid (ddr_data_valid)
    );

    always #20 clk = ~clk;

    // memory holds 0xd on top and the word address below
    function automatic bus_data_t lane_value(input word_addr_t a);
        return {4'hd, a};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("at %0t ns: %s", $time, msg);
    endtask

    // random back-pressure on both ready inputs
    always @(posedge clk) begin
        #2;
        rd_data_ready  = ($urandom % 100) >= stall_pct;
        ddr_addr_ready = ($urandom % 100) >= 30;
    end

    // upstream beat checker on the falling edge
    always @(negedge clk) begin : beat_check
        bus_data_t exp_data;
        if (rstn && rd_data_valid && !req_active) begin
            report_problem("rd_data_valid high with no request in progress");
        end
        if (req_active && rd_addr_ready) begin
            report_problem("rd_addr_ready high while a request is in progress");
        end
        if (req_active && rd_data_valid && rd_data_ready) begin
            exp_data = lane_value(cur_addr + word_addr_t'(beats_seen));
            if (rd_data !== exp_data) begin
                report_mismatch("rd_data", rd_data, exp_data);
            end
            if (rd_back_id !== cur_id) begin
                report_mismatch("rd_back_id", rd_back_id, cur_id);
            end
            if (rd_data_resp !== 2'b00) begin
                report_mismatch("rd_data_resp", rd_data_resp, 0);
            end
            if (rd_data_last !== (beats_seen == int'(cur_len))) begin
                report_mismatch("rd_data_last", rd_data_last, beats_seen == int'(cur_len));
            end
            beats_seen++;
            beats_total++;
            if (rd_data_last) begin
                req_active = 1'b0;
            end
        end
    end

    // DDR controller model with one burst outstanding
    always @(negedge clk) begin : ddr_model
        int         gap;
        int         blen;
        int         popped;
        int         consumed;
        int         stored;
        word_addr_t baddr;
        if (rstn && ddr_addr_valid && ddr_addr_ready) begin
            #1;   // beat checker of this cycle has run by now
            bursts_total++;
            blen  = int'(ddr_len);
            baddr = ddr_addr;
            if (baddr !== next_burst_addr) begin
                report_mismatch("ddr_addr", baddr, next_burst_addr);
            end
            if (ddr_id !== cur_id) begin
                report_mismatch("ddr_id", ddr_id, cur_id);
            end
            consumed = beats_seen;
            if (rd_data_valid && rd_data_ready) begin
                consumed--;   // that beat leaves the FIFO only at the next edge
            end
            // head pointer moves once 8 lanes are gone and discards count too
            popped = (consumed > 0) ? int'(cur_addr[2:0]) + consumed : 0;
            stored = words_written - popped / 8;
            if (stored > FIFO_DEPTH - DDR_BURST_MAX) begin
                report_problem($sformatf("burst issued with %0d wide words still stored", stored));
            end
            words_asked += blen + 1;
            next_burst_addr = baddr + word_addr_t'(8 * (blen + 1));
            gap = 2 + ($urandom % 9);
            @(posedge clk);
            repeat (gap - 1) @(posedge clk);
            for (int j = 0; j <= blen; j++) begin
                #2;
                for (int k = 0; k < 8; k++) begin
                    ddr_data[32*k +: 32] = lane_value(baddr + word_addr_t'(8 * j + k));
                end
                ddr_back_id    = cur_id;
                ddr_data_last  = (j == blen);
                ddr_data_valid = 1'b1;
                @(posedge clk);
                words_written++;
            end
            #2;
            ddr_data_valid = 1'b0;
            ddr_data_last  = 1'b0;
        end
    end

    initial begin : main
        int    fd;
        int    n;
        int    wait_cnt;
        int    needed;
        int    id_v;
        int    addr_v;
        int    len_v;
        int    pct_v;
        string line;
        logic  timed_out;
        void'($urandom(32'h2ecbe4c4));
        clk = 1'b0;
        rstn = 1'b0;
        rd_addr_id = '0;
        rd_addr = '0;
        rd_addr_len = '0;
        rd_addr_valid = 1'b0;
        rd_data_ready = 1'b0;
        ddr_addr_ready = 1'b0;
        ddr_data = '0;
        ddr_back_id = '0;
        ddr_data_last = 1'b0;
        ddr_data_valid = 1'b0;
        errors = 0;
        beats_total = 0;
        bursts_total = 0;
        stall_pct = 0;
        req_active = 1'b0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(negedge clk);
        if (rd_addr_ready !== 1'b1) begin
            report_mismatch("rd_addr_ready", rd_addr_ready, 1);
        end
        if (rd_data_valid !== 1'b0 || ddr_addr_valid !== 1'b0) begin
            report_problem("valid outputs not low after reset");
        end
        fd = $fopen("dv/ddr_read_patterns.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open dv/ddr_read_patterns.txt");
        end
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %d", id_v, addr_v, len_v, pct_v) != 4) begin
                report_problem("pattern line could not be parsed");
                continue;
            end
            @(posedge clk);
            #2;
            cur_id = bus_id_t'(id_v);
            cur_addr = word_addr_t'(addr_v);
            cur_len = beat_len_t'(len_v);
            stall_pct = pct_v;
            beats_seen = 0;
            words_asked = 0;
            words_written = 0;
            next_burst_addr = {cur_addr[27:3], 3'b000};
            rd_addr_id = cur_id;
            rd_addr = cur_addr;
            rd_addr_len = cur_len;
            rd_addr_valid = 1'b1;
            wait_cnt = 0;
            forever begin   // address handshake
                @(negedge clk);
                if (rd_addr_ready === 1'b1) begin
                    break;
                end
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    report_problem("timeout waiting for rd_addr_ready");
                    timed_out = 1'b1;
                    break;
                end
            end
            if (timed_out) begin
                break;
            end
            @(posedge clk);
            #2;
            rd_addr_valid = 1'b0;
            req_active = 1'b1;
            wait_cnt = 0;
            while (req_active && !timed_out) begin
                @(posedge clk);
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    report_problem("timeout waiting for the last beat");
                    timed_out = 1'b1;
                end
            end
            needed = ((addr_v + len_v) >> 3) - (addr_v >> 3) + 1;
            if (!timed_out && beats_seen != len_v + 1) begin
                report_problem($sformatf("%0d beats arrived, %0d expected", beats_seen, len_v + 1));
            end
            if (!timed_out && words_asked != needed) begin
                report_problem($sformatf("%0d wide words requested, %0d needed", words_asked, needed));
            end
        end
        $display("errors: %0d, beats checked: %0d, DDR bursts: %0d",
                 errors, beats_total, bursts_total);
        if (errors == 0 && !timed_out && beats_total > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/ddr_read_patterns.txt
# id(hex) start_addr(hex) len_code(hex) ready_stall_pct(decimal)
# beat i of a request is expected to hold 0xd in the top nibble and start_addr+i below
1 0000100 00 0
2 0000208 07 0
3 0000301 00 10
4 0000407 07 20
5 0000503 0c 0
6 0000605 1d 30
7 0001000 ff 0
8 0002004 ff 25
9 0003007 ff 75
a 0004002 3f 75
b 0005006 16 75
c 0006000 0f 50
d 0006001 01 0
e ffffff0 0f 0
f 0000100 07 75
0 0000101 fe 10

//--- all.f
logic/ddr_read_pkg.sv
logic/ddr_read_fifo.sv
logic/ddr_read_ctrl.sv
logic/ddr_read_top.sv
dv/tb_ddr_read.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_ddr_read
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing -Wno-fatal

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx '=== PASS ===' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
